//--- source/core_pkg.sv
// ==========================================================================
// Shared definitions for the issue-and-writeback core slice
// Instructions are one 32-bit word with the opcode in the top six bits
// Opcode values not listed in opcode_e are legal and produce no result
// Field positions below assume the fixed INSTR_W of 32
// ==========================================================================
`default_nettype none

package core_pkg;

	// Instruction word width, fixed for this core
	localparam int INSTR_W = 32;

	// Register address width for the 32-entry register file
	localparam int REG_AW = 5;

	// ======================================================================
	// Opcodes and internal operation codes
	// ======================================================================

	// NOP must stay at zero so that an all-zero word does nothing
	typedef enum logic [5:0] {
		NOP  = 6'h00,
		ADD  = 6'h01,
		SUB  = 6'h02,
		AND  = 6'h03,
		OR   = 6'h04,
		XOR  = 6'h05,
		SLT  = 6'h06,
		ADDI = 6'h08,
		ANDI = 6'h09,
		ORI  = 6'h0A,
		XORI = 6'h0B,
		SLTI = 6'h0C,
		LDI  = 6'h0D,
		JMP  = 6'h10,
		JEQ  = 6'h11,
		JNE  = 6'h12
	} opcode_e;

	// ALU_PASSB forwards operand B, used by LDI
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_PASSB
	} alu_op_e;

	typedef enum logic [1:0] {
		BR_NONE,
		BR_ALWAYS,
		BR_EQ,
		BR_NE
	} br_kind_e;

	// ======================================================================
	// Field positions within the instruction word
	// ======================================================================
	localparam int OP_HI   = 31;
	localparam int OP_LO   = 26;
	localparam int RD_HI   = 25;
	localparam int RD_LO   = 21;
	localparam int RA_HI   = 20;
	localparam int RA_LO   = 16;
	localparam int RB_HI   = 15;
	localparam int RB_LO   = 11;
	localparam int IMM_HI  = 15;
	localparam int IMM_LO  = 0;
	localparam int IMM_W   = IMM_HI - IMM_LO + 1;
	// Jump displacement counts in words and is signed
	localparam int DISP_HI = 8;
	localparam int DISP_LO = 0;
	localparam int DISP_W  = DISP_HI - DISP_LO + 1;
	// Link field of the jump group, nonzero means write the return address
	localparam int LK_HI   = 10;
	localparam int LK_LO   = 9;

endpackage

`default_nettype wire

//--- source/core_decode_rfwr.sv
// ==========================================================================
// Opcode decode for register write, ALU operation and operand selection
// Purely combinational, driven from the latched instruction register
// Unlisted opcodes decode as no write, no immediate and no branch
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module core_decode_rfwr
	import core_pkg::*;
(
	input  opcode_e  opcode,
	input  logic [1:0] lk,
	output logic     rfwr,
	output alu_op_e  alu_op,
	output logic     use_imm,
	output logic     imm_signed,
	output br_kind_e br_kind
);

	// ======================================================================
	// Register file update detection
	// ======================================================================
	always_comb
	begin
		rfwr = 1'b0;
		case (opcode)
		ADD, SUB, AND, OR, XOR, SLT:
			rfwr = 1'b1;
		ADDI, ANDI, ORI, XORI, SLTI:
			rfwr = 1'b1;
		LDI:
			rfwr = 1'b1;
		// Jumps only write rd when a link is requested
		JMP, JEQ, JNE:
			rfwr = lk != 2'b00;
		default:
			rfwr = 1'b0;
		endcase
	end

	// ======================================================================
	// ALU operation and branch kind
	// ======================================================================
	always_comb
	begin
		alu_op  = ALU_ADD;
		br_kind = BR_NONE;
		case (opcode)
		ADD, ADDI:	alu_op = ALU_ADD;
		SUB:		alu_op = ALU_SUB;
		AND, ANDI:	alu_op = ALU_AND;
		OR, ORI:	alu_op = ALU_OR;
		XOR, XORI:	alu_op = ALU_XOR;
		SLT, SLTI:	alu_op = ALU_SLT;
		LDI:		alu_op = ALU_PASSB;
		// The jump result comes from the link value, so the ALU op is unused
		JMP:		br_kind = BR_ALWAYS;
		JEQ:		br_kind = BR_EQ;
		JNE:		br_kind = BR_NE;
		default:	alu_op = ALU_ADD;
		endcase
	end

	// Immediate group takes operand B from the instruction word
	assign use_imm = opcode inside {ADDI, ANDI, ORI, XORI, SLTI, LDI};

	// Logic immediates are zero extended, everything else is sign extended
	assign imm_signed = !(opcode inside {ANDI, ORI, XORI});

endmodule

`default_nettype wire

//--- source/core_regfile.sv
// ==========================================================================
// 32-entry register file, two asynchronous reads and one synchronous write
// Register 0 has no storage and always reads zero
// Reset clears every entry so that reads after reset are defined
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module core_regfile
	import core_pkg::*;
#(
	parameter int DATA_W = 32
)
(
	input  logic              clk,
	input  logic              arst_n,
	input  logic [REG_AW-1:0] raddr_a,
	input  logic [REG_AW-1:0] raddr_b,
	output logic [DATA_W-1:0] rdata_a,
	output logic [DATA_W-1:0] rdata_b,
	input  logic              we,
	input  logic [REG_AW-1:0] waddr,
	input  logic [DATA_W-1:0] wdata
);

	localparam int NUM_REGS = 1 << REG_AW;

	// Entries 1 and up, entry 0 is implied
	logic [DATA_W-1:0] regs [1:NUM_REGS-1];

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 1; i < NUM_REGS; i++)
				regs[i] <= '0;
		end
		else
		begin
			// Each entry only loads on its own address match
			for (int i = 1; i < NUM_REGS; i++)
				if (we && waddr == REG_AW'(i))
					regs[i] <= wdata;
		end
	end

	assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
	assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

	// The control block gates writes to r0, so none should reach here
	a_no_r0_write: assert property (@(posedge clk) disable iff (!arst_n)
		we |-> waddr != '0);

endmodule

`default_nettype wire

//--- source/core_alu.sv
// ==========================================================================
// Integer ALU with an equality flag for conditional jumps
// Set-less-than is signed and returns 1 or 0 in the full width
// No overflow or carry flags are produced
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module core_alu
	import core_pkg::*;
#(
	parameter int DATA_W = 32
)
(
	input  alu_op_e           op,
	input  logic [DATA_W-1:0] a,
	input  logic [DATA_W-1:0] b,
	output logic [DATA_W-1:0] result,
	output logic              eq
);

	logic lt;

	// Signed compare shared by SLT and SLTI
	assign lt = $signed(a) < $signed(b);

	always_comb
	begin
		result = '0;
		case (op)
		ALU_ADD:
			result = a + b;
		ALU_SUB:
			result = a - b;
		ALU_AND:
			result = a & b;
		ALU_OR:
			result = a | b;
		ALU_XOR:
			result = a ^ b;
		ALU_SLT:
			result = {{(DATA_W-1){1'b0}}, lt};
		// LDI hands the extended immediate straight through
		ALU_PASSB:
			result = b;
		default:
			result = '0;
		endcase
	end

	// JEQ and JNE compare the two register operands
	assign eq = a == b;

endmodule

`default_nettype wire

//--- source/core_control.sv
// ==========================================================================
// Handshake FSM, program counter, operand B select and write sequencing
// One instruction at a time over four-phase req/ack, no overlap
// Writeback, pc update and ack all appear one cycle after acceptance
// Requires DATA_W above PC_W and PC_W above the displacement width
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module core_control
	import core_pkg::*;
#(
	parameter int DATA_W = 32,
	parameter int PC_W   = 16
)
(
	input  logic               clk,
	input  logic               arst_n,
	input  logic               instr_req,
	input  logic [INSTR_W-1:0] instr,
	output logic               instr_ack,
	output opcode_e            opcode,
	output logic [1:0]         lk,
	output logic [REG_AW-1:0]  ra_addr,
	output logic [REG_AW-1:0]  rb_addr,
	input  logic               rfwr,
	input  logic               use_imm,
	input  logic               imm_signed,
	input  br_kind_e           br_kind,
	input  logic [DATA_W-1:0]  rb_data,
	output logic [DATA_W-1:0]  alu_b,
	input  logic [DATA_W-1:0]  alu_result,
	input  logic               eq,
	output logic               we,
	output logic [REG_AW-1:0]  waddr,
	output logic [DATA_W-1:0]  wdata,
	output logic               wb_valid,
	output logic [REG_AW-1:0]  wb_reg,
	output logic [DATA_W-1:0]  wb_data,
	output logic [PC_W-1:0]    pc
);

	typedef enum logic [1:0] {IDLE, EXEC, DONE} state_e;

	state_e             state;
	logic [INSTR_W-1:0] instr_q;
	logic [REG_AW-1:0]  rd;
	logic [IMM_W-1:0]   imm;
	logic [DATA_W-1:0]  imm_ext;
	logic [DISP_W-1:0]  disp;
	logic [PC_W-1:0]    pc_inc;
	logic [PC_W-1:0]    pc_taken;
	logic [DATA_W-1:0]  link;
	logic               taken;
	logic               wr_en;
	logic [DATA_W-1:0]  wr_data;

	// ======================================================================
	// Field extraction and operand B
	// ======================================================================
	assign opcode  = opcode_e'(instr_q[OP_HI:OP_LO]);
	assign lk      = instr_q[LK_HI:LK_LO];
	assign rd      = instr_q[RD_HI:RD_LO];
	assign ra_addr = instr_q[RA_HI:RA_LO];
	assign rb_addr = instr_q[RB_HI:RB_LO];
	assign imm     = instr_q[IMM_HI:IMM_LO];
	assign disp    = instr_q[DISP_HI:DISP_LO];

	assign imm_ext = imm_signed ? {{(DATA_W-IMM_W){imm[IMM_W-1]}}, imm}
		: {{(DATA_W-IMM_W){1'b0}}, imm};
	assign alu_b   = use_imm ? imm_ext : rb_data;

	// ======================================================================
	// Next pc and link value
	// ======================================================================
	assign pc_inc   = pc + 1'b1;
	// Displacement is relative to the following instruction
	assign pc_taken = pc_inc + {{(PC_W-DISP_W){disp[DISP_W-1]}}, disp};
	assign link     = {{(DATA_W-PC_W){1'b0}}, pc_inc};

	always_comb
	begin
		case (br_kind)
		BR_ALWAYS:	taken = 1'b1;
		BR_EQ:		taken = eq;
		BR_NE:		taken = !eq;
		default:	taken = 1'b0;
		endcase
	end

	// Jumps write the return address, all else writes the ALU result
	assign wr_data = (br_kind != BR_NONE) ? link : alu_result;
	// A write to r0 is dropped and so not reported either
	assign wr_en   = rfwr && rd != '0;

	// The register file commits on the EXEC edge along with the pc
	assign we    = (state == EXEC) && wr_en;
	assign waddr = rd;
	assign wdata = wr_data;

	// ======================================================================
	// Handshake FSM and pc
	// ======================================================================
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state     <= IDLE;
			instr_ack <= 1'b0;
			wb_valid  <= 1'b0;
			pc        <= '0;
		end
		else
		begin
			// The writeback report is a single-cycle pulse
			wb_valid <= 1'b0;
			case (state)
			IDLE:
				if (instr_req)
					state <= EXEC;
			EXEC:
			begin
				pc        <= taken ? pc_taken : pc_inc;
				wb_valid  <= wr_en;
				instr_ack <= 1'b1;
				state     <= DONE;
			end
			// Hold ack until the producer lets go of req
			DONE:
				if (!instr_req)
				begin
					instr_ack <= 1'b0;
					state     <= IDLE;
				end
			default:
				state <= IDLE;
			endcase
		end
	end

	// Instruction word and writeback payload
	always_ff @(posedge clk)
	begin
		if (state == IDLE && instr_req)
			instr_q <= instr;
		if (state == EXEC)
		begin
			wb_reg  <= rd;
			wb_data <= wr_data;
		end
	end

	// ======================================================================
	// Protocol checks
	// ======================================================================
	a_ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(instr_ack) |-> instr_req);

	a_wb_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
		wb_valid |=> !wb_valid);

	a_instr_stable: assert property (@(posedge clk) disable iff (!arst_n)
		(instr_req && !instr_ack) |=> $stable(instr));

endmodule

`default_nettype wire

//--- source/core_top.sv
// ==========================================================================
// Top level of the core slice, control plus decoder, register file and ALU
// DATA_W may be 32 or 64, PC_W must stay below DATA_W
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module core_top
	import core_pkg::*;
#(
	parameter int DATA_W = 32,
	parameter int PC_W   = 16
)
(
	input  logic               clk,
	input  logic               arst_n,
	input  logic               instr_req,
	input  logic [INSTR_W-1:0] instr,
	output logic               instr_ack,
	output logic               wb_valid,
	output logic [REG_AW-1:0]  wb_reg,
	output logic [DATA_W-1:0]  wb_data,
	output logic [PC_W-1:0]    pc
);

	opcode_e           opcode;
	logic [1:0]        lk;
	logic [REG_AW-1:0] ra_addr;
	logic [REG_AW-1:0] rb_addr;
	logic [DATA_W-1:0] ra_data;
	logic [DATA_W-1:0] rb_data;
	logic              rfwr;
	alu_op_e           alu_op;
	logic              use_imm;
	logic              imm_signed;
	br_kind_e          br_kind;
	logic [DATA_W-1:0] alu_b;
	logic [DATA_W-1:0] alu_result;
	logic              eq;
	logic              we;
	logic [REG_AW-1:0] waddr;
	logic [DATA_W-1:0] wdata;

	core_control #(.DATA_W(DATA_W), .PC_W(PC_W)) u_control (
		.clk(clk), .arst_n(arst_n),
		.instr_req(instr_req), .instr(instr), .instr_ack(instr_ack),
		.opcode(opcode), .lk(lk), .ra_addr(ra_addr), .rb_addr(rb_addr),
		.rfwr(rfwr), .use_imm(use_imm), .imm_signed(imm_signed), .br_kind(br_kind),
		.rb_data(rb_data), .alu_b(alu_b), .alu_result(alu_result), .eq(eq),
		.we(we), .waddr(waddr), .wdata(wdata),
		.wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data), .pc(pc)
	);

	core_decode_rfwr u_decode (
		.opcode(opcode), .lk(lk), .rfwr(rfwr), .alu_op(alu_op),
		.use_imm(use_imm), .imm_signed(imm_signed), .br_kind(br_kind)
	);

	core_regfile #(.DATA_W(DATA_W)) u_regfile (
		.clk(clk), .arst_n(arst_n),
		.raddr_a(ra_addr), .raddr_b(rb_addr), .rdata_a(ra_data), .rdata_b(rb_data),
		.we(we), .waddr(waddr), .wdata(wdata)
	);

	// Operand A always comes straight from the register file
	core_alu #(.DATA_W(DATA_W)) u_alu (
		.op(alu_op), .a(ra_data), .b(alu_b), .result(alu_result), .eq(eq)
	);

endmodule

`default_nettype wire

//--- sim/tb_clock.sv
// ==========================================================================
// Clock and reset source for the core testbench
// Reset lifts on a falling clock edge, clear of the active rising edge
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD_NS    = 40,
	parameter int RESET_CYCLES = 3
)
(
	output logic clk,
	output logic arst_n
);

	// Free-running clock, first rising edge at half a period
	initial
	begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// Whole periods of reset end exactly on a falling edge
	initial
	begin
		arst_n = 1'b0;
		#(RESET_CYCLES * PERIOD_NS);
		arst_n = 1'b1;
	end

endmodule

`default_nettype wire

//--- sim/tb_core_top.sv
// ==========================================================================
// Random instruction testbench for the core slice with a reference model
// Producer side follows four-phase req/ack with random gaps and stalls
// Inputs change on rising edges, outputs are sampled on falling edges
// Model assumes DATA_W of 32 and PC_W of 16 as set here
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module tb_core_top
	import core_pkg::*;
();

	localparam int DATA_W         = 32;
	localparam int PC_W           = 16;
	localparam int NUM_INSTR      = 400;
	// No instruction needs more than a dozen cycles even with the longest gap and stall
	localparam int TIMEOUT_CYCLES = NUM_INSTR * 12;

	logic               clk;
	logic               arst_n;
	logic               instr_req;
	logic [INSTR_W-1:0] instr;
	logic               instr_ack;
	logic               wb_valid;
	logic [REG_AW-1:0]  wb_reg;
	logic [DATA_W-1:0]  wb_data;
	logic [PC_W-1:0]    pc;

	integer            seed = 32'h59f09649;
	int                errors = 0;
	int                checks = 0;
	int                cycles = 0;
	logic [DATA_W-1:0] model_regs [0:31];
	logic [PC_W-1:0]   model_pc;
	opcode_e           op_table [0:15];

	tb_clock #(.PERIOD_NS(40), .RESET_CYCLES(3)) u_clock (.clk(clk), .arst_n(arst_n));

	core_top #(.DATA_W(DATA_W), .PC_W(PC_W)) u_core_top (
		.clk(clk), .arst_n(arst_n),
		.instr_req(instr_req), .instr(instr), .instr_ack(instr_ack),
		.wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data), .pc(pc)
	);

	// ======================================================================
	// Checking and stimulus helpers
	// ======================================================================
	task automatic compare(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("** Error at %0t: %s expected 0x%0h, got 0x%0h",
				$time, name, expected, actual);
		end
	endtask

	// Mostly r0 to r7 so that results come back as operands soon
	function automatic logic [REG_AW-1:0] pick_reg();
		if ({$random(seed)} % 4 != 0)
			return REG_AW'(3'($random(seed)));
		return REG_AW'($random(seed));
	endfunction

	function automatic logic [INSTR_W-1:0] make_instr();
		logic [INSTR_W-1:0] w;
		logic [4:0]         pick;
		logic               imm_form;
		w    = $random(seed);
		pick = 5'({$random(seed)} % 18);
		imm_form = 1'b0;
		if (pick < 16)
		begin
			w[OP_HI:OP_LO] = op_table[pick[3:0]];
			imm_form = op_table[pick[3:0]] inside {ADDI, ANDI, ORI, XORI, SLTI, LDI};
		end
		else
			// Any 6-bit value, often one the core does not define
			w[OP_HI:OP_LO] = 6'($random(seed));
		w[RD_HI:RD_LO] = pick_reg();
		w[RA_HI:RA_LO] = pick_reg();
		// Immediate forms keep all sixteen random immediate bits
		if (!imm_form)
			w[RB_HI:RB_LO] = pick_reg();
		return w;
	endfunction

	// ======================================================================
	// Reference model of one instruction
	// ======================================================================
	task automatic predict(
		input  logic [INSTR_W-1:0] w,
		output logic               wr,
		output logic [REG_AW-1:0]  rd,
		output logic [DATA_W-1:0]  data,
		output logic [PC_W-1:0]    next_pc
	);
		opcode_e           op;
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
		logic [DATA_W-1:0] simm;
		logic [DATA_W-1:0] zimm;
		logic [PC_W-1:0]   seq_pc;
		logic [PC_W-1:0]   disp;
		logic              taken;
		op     = opcode_e'(w[OP_HI:OP_LO]);
		rd     = w[RD_HI:RD_LO];
		// Entry 0 of the model is never written and so reads zero
		a      = model_regs[w[RA_HI:RA_LO]];
		b      = model_regs[w[RB_HI:RB_LO]];
		simm   = DATA_W'($signed(w[IMM_HI:IMM_LO]));
		zimm   = DATA_W'(w[IMM_HI:IMM_LO]);
		seq_pc = model_pc + 1'b1;
		disp   = PC_W'($signed(w[DISP_HI:DISP_LO]));
		case (op)
		ADD:           data = a + b;
		SUB:           data = a - b;
		AND:           data = a & b;
		OR:            data = a | b;
		XOR:           data = a ^ b;
		SLT:           data = DATA_W'($signed(a) < $signed(b));
		ADDI:          data = a + simm;
		ANDI:          data = a & zimm;
		ORI:           data = a | zimm;
		XORI:          data = a ^ zimm;
		SLTI:          data = DATA_W'($signed(a) < $signed(simm));
		LDI:           data = simm;
		JMP, JEQ, JNE: data = DATA_W'(seq_pc);
		default:       data = '0;
		endcase
		wr = op inside {ADD, SUB, AND, OR, XOR, SLT, ADDI, ANDI, ORI, XORI, SLTI, LDI};
		// Jumps only produce a result when they carry a link
		if (op inside {JMP, JEQ, JNE})
			wr = w[LK_HI:LK_LO] != 2'b00;
		wr      = wr && rd != '0;
		taken   = (op == JMP) || (op == JEQ && a == b) || (op == JNE && a != b);
		next_pc = taken ? seq_pc + disp : seq_pc;
	endtask

	// ======================================================================
	// One full handshake with checks at every sampled cycle
	// ======================================================================
	task automatic send_instr(input logic [INSTR_W-1:0] w);
		logic              exp_wr;
		logic [REG_AW-1:0] exp_rd;
		logic [DATA_W-1:0] exp_data;
		logic [PC_W-1:0]   exp_pc;
		int                gap;
		int                hold;
		int                low_count;
		predict(w, exp_wr, exp_rd, exp_data, exp_pc);
		gap = {$random(seed)} % 4;
		repeat (gap) @(posedge clk);
		@(posedge clk);
		instr_req <= 1'b1;
		instr     <= w;
		low_count = 0;
		@(negedge clk);
		while (!instr_ack)
		begin
			compare("wb_valid", 64'd0, 64'(wb_valid));
			low_count++;
			@(negedge clk);
		end
		// Req is seen on the next edge and ack follows one edge later
		compare("instr_ack delay", 64'd2, 64'(low_count));
		compare("wb_valid", 64'(exp_wr), 64'(wb_valid));
		if (exp_wr)
		begin
			compare("wb_reg", 64'(exp_rd), 64'(wb_reg));
			compare("wb_data", 64'(exp_data), 64'(wb_data));
			model_regs[exp_rd] = exp_data;
		end
		compare("pc", 64'(exp_pc), 64'(pc));
		model_pc = exp_pc;
		// Producer stalls before letting go, ack must stay up meanwhile
		hold = {$random(seed)} % 3;
		repeat (hold)
		begin
			@(negedge clk);
			compare("instr_ack", 64'd1, 64'(instr_ack));
			compare("wb_valid", 64'd0, 64'(wb_valid));
		end
		@(posedge clk);
		instr_req <= 1'b0;
		@(negedge clk);
		// Core has not yet seen req low on this cycle
		compare("instr_ack", 64'd1, 64'(instr_ack));
		while (instr_ack)
		begin
			compare("wb_valid", 64'd0, 64'(wb_valid));
			@(negedge clk);
		end
	endtask

	// ======================================================================
	// Main sequence and run limit
	// ======================================================================
	initial
	begin
		logic [INSTR_W-1:0] w;
		$timeformat(-9, 0, " ns", 0);
		op_table = '{ADD, SUB, AND, OR, XOR, SLT, ADDI, ANDI, ORI, XORI, SLTI, LDI,
			JMP, JEQ, JNE, NOP};
		for (int i = 0; i < 32; i++)
			model_regs[i] = '0;
		model_pc = '0;
		instr_req <= 1'b0;
		instr     <= '0;
		@(posedge arst_n);
		@(posedge clk);
		@(negedge clk);
		// State right after reset
		compare("instr_ack", 64'd0, 64'(instr_ack));
		compare("wb_valid", 64'd0, 64'(wb_valid));
		compare("pc", 64'd0, 64'(pc));
		for (int n = 0; n < NUM_INSTR; n++)
		begin
			w = make_instr();
			send_instr(w);
		end
		$display("Result: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: the handshake did not finish within %0d cycles", cycles);
			$display("Done: errors found");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- src.f
source/core_pkg.sv
source/core_decode_rfwr.sv
source/core_regfile.sv
source/core_alu.sv
source/core_control.sv
source/core_top.sv
sim/tb_clock.sv
sim/tb_core_top.sv

//--- Makefile
# Verilator build and run of the core testbench

TOP = tb_core_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f src.f --top-module $(TOP) -Mdir obj_dir -o sim_core

# The log decides pass or fail
run: compile
	./obj_dir/sim_core | tee sim.log
	grep -qx "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log
